//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_port
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_mem_port.sv
// clock, reset, LFSR, check task, directed tests and watchdog for the memory port merger

`timescale 1ns/1ps

module tb_mem_port;

    localparam int TEST_CYCLES = 80;   // sum of the directed test lengths
    localparam int MARGIN      = 100;

    logic clk_i, rst_n_i;
    logic fetch_ar_valid_i, bypass_ar_valid_i, dcache_ar_valid_i;
    mem_port_pkg::addr_t fetch_ar_addr_i, bypass_ar_addr_i, dcache_ar_addr_i;
    mem_port_pkg::id_t fetch_ar_id_i, bypass_ar_id_i, dcache_ar_id_i;
    logic fetch_ar_ready_o, bypass_ar_ready_o, dcache_ar_ready_o;
    logic fetch_r_valid_o, bypass_r_valid_o, dcache_r_valid_o;
    mem_port_pkg::data_t fetch_r_data_o, bypass_r_data_o, dcache_r_data_o;
    mem_port_pkg::id_t fetch_r_id_o, bypass_r_id_o, dcache_r_id_o;
    logic fetch_r_last_o, bypass_r_last_o, dcache_r_last_o;
    logic fetch_r_ready_i, bypass_r_ready_i, dcache_r_ready_i;
    logic bypass_aw_valid_i, dcache_aw_valid_i, bypass_aw_ready_o, dcache_aw_ready_o;
    mem_port_pkg::addr_t bypass_aw_addr_i, dcache_aw_addr_i;
    mem_port_pkg::id_t bypass_aw_id_i, dcache_aw_id_i;
    logic bypass_w_valid_i, dcache_w_valid_i, bypass_w_last_i, dcache_w_last_i;
    mem_port_pkg::data_t bypass_w_data_i, dcache_w_data_i;
    logic bypass_w_ready_o, dcache_w_ready_o;
    logic bypass_b_valid_o, dcache_b_valid_o, bypass_b_ready_i, dcache_b_ready_i;
    mem_port_pkg::id_t bypass_b_id_o, dcache_b_id_o;
    logic mem_ar_valid_o, mem_ar_ready_i, mem_aw_valid_o, mem_aw_ready_i;
    mem_port_pkg::addr_t mem_ar_addr_o, mem_aw_addr_o;
    mem_port_pkg::id_t mem_ar_id_o, mem_aw_id_o, mem_r_id_i, mem_b_id_i;
    logic mem_w_valid_o, mem_w_last_o, mem_w_ready_i;
    mem_port_pkg::data_t mem_w_data_o, mem_r_data_i;
    logic mem_r_valid_i, mem_r_last_i, mem_r_ready_o, mem_b_valid_i, mem_b_ready_o;

    int          errors = 0;
    logic [31:0] lfsr_q = 32'd91614;

    mem_port_top mem_port_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    // taps 32,22,2,1
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic reset_state();
        @(negedge clk_i);
        check("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd0);
        check("mem_aw_valid_o", 64'(mem_aw_valid_o), 64'd0);
        check("mem_w_valid_o", 64'(mem_w_valid_o), 64'd0);
        check("w_ready_o", 64'({bypass_w_ready_o, dcache_w_ready_o}), 64'd0);
        check("r_valid_o", 64'({fetch_r_valid_o, bypass_r_valid_o, dcache_r_valid_o}), 64'd0);
        check("b_valid_o", 64'({bypass_b_valid_o, dcache_b_valid_o}), 64'd0);
    endtask

    task automatic ar_round_robin();
        logic [3:0]  ids [3];
        logic [31:0] addrs [3];
        ids = '{4'b0000, 4'b1001, 4'b1100};
        for (int i = 0; i < 3; i++) addrs[i] = 32'(rand_bits(32));
        @(posedge clk_i);
        fetch_ar_valid_i  <= 1'b1;
        fetch_ar_id_i     <= ids[0];
        fetch_ar_addr_i   <= addrs[0];
        bypass_ar_valid_i <= 1'b1;
        bypass_ar_id_i    <= ids[1];
        bypass_ar_addr_i  <= addrs[1];
        dcache_ar_valid_i <= 1'b1;
        dcache_ar_id_i    <= ids[2];
        dcache_ar_addr_i  <= addrs[2];
        mem_ar_ready_i    <= 1'b1;
        for (int k = 0; k < 6; k++) begin
            @(negedge clk_i);   // fetch, bypass, dcache, repeating
            check("mem_ar_id_o", 64'(mem_ar_id_o), 64'(ids[k % 3]));
            check("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(addrs[k % 3]));
            check("ar_ready_o", 64'({dcache_ar_ready_o, bypass_ar_ready_o, fetch_ar_ready_o}),
                  64'(3'b001 << (k % 3)));
        end
        @(posedge clk_i);
        fetch_ar_valid_i  <= 1'b0;
        bypass_ar_valid_i <= 1'b0;
        dcache_ar_valid_i <= 1'b0;
        mem_ar_ready_i    <= 1'b0;
    endtask

    task automatic ar_backpressure();
        int stall;
        stall = int'(rand_bits(3)) + 2;
        @(posedge clk_i);
        bypass_ar_valid_i <= 1'b1;
        bypass_ar_id_i    <= 4'b1010;
        bypass_ar_addr_i  <= 32'(rand_bits(32));
        fetch_ar_id_i     <= 4'b0000;
        fetch_ar_addr_i   <= 32'(rand_bits(32));
        @(negedge clk_i);
        check("mem_ar_id_o", 64'(mem_ar_id_o), 64'(4'b1010));
        @(posedge clk_i);
        fetch_ar_valid_i <= 1'b1;   // competitor arrives during the stall
        for (int i = 0; i < stall; i++) begin
            @(negedge clk_i);
            check("mem_ar_id_o", 64'(mem_ar_id_o), 64'(bypass_ar_id_i));
            check("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(bypass_ar_addr_i));
            check("fetch_ar_ready_o", 64'(fetch_ar_ready_o), 64'd0);
        end
        @(posedge clk_i);
        mem_ar_ready_i <= 1'b1;
        @(negedge clk_i);
        check("mem_ar_id_o", 64'(mem_ar_id_o), 64'(bypass_ar_id_i));
        check("bypass_ar_ready_o", 64'(bypass_ar_ready_o), 64'd1);
        check("fetch_ar_ready_o", 64'(fetch_ar_ready_o), 64'd0);
        @(posedge clk_i);
        bypass_ar_valid_i <= 1'b0;
        @(negedge clk_i);
        check("mem_ar_id_o", 64'(mem_ar_id_o), 64'(fetch_ar_id_i));
        check("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(fetch_ar_addr_i));
        check("fetch_ar_ready_o", 64'(fetch_ar_ready_o), 64'd1);
        @(posedge clk_i);
        fetch_ar_valid_i <= 1'b0;
        mem_ar_ready_i   <= 1'b0;
    endtask

    // one expected W beat at memory with only the head master ready
    task automatic expect_w(input logic [63:0] data, input logic last, input logic byp);
        @(negedge clk_i);
        check("mem_w_valid_o", 64'(mem_w_valid_o), 64'd1);
        check("mem_w_data_o", mem_w_data_o, data);
        check("mem_w_last_o", 64'(mem_w_last_o), 64'(last));
        check("bypass_w_ready_o", 64'(bypass_w_ready_o), 64'(byp));
        check("dcache_w_ready_o", 64'(dcache_w_ready_o), 64'(!byp));
    endtask

    task automatic write_steer();
        logic [63:0] b0, b1, d0, d1;
        b0 = rand_bits(64);
        b1 = rand_bits(64);
        d0 = rand_bits(64);
        d1 = rand_bits(64);
        @(posedge clk_i);
        mem_aw_ready_i    <= 1'b1;
        mem_w_ready_i     <= 1'b1;
        bypass_aw_valid_i <= 1'b1;
        bypass_aw_id_i    <= 4'b1001;
        bypass_aw_addr_i  <= 32'(rand_bits(32));
        bypass_w_valid_i  <= 1'b1;
        bypass_w_data_i   <= b0;
        bypass_w_last_i   <= 1'b0;
        @(negedge clk_i);
        check("mem_aw_id_o", 64'(mem_aw_id_o), 64'(4'b1001));
        check("mem_aw_addr_o", 64'(mem_aw_addr_o), 64'(bypass_aw_addr_i));
        check("mem_w_valid_o", 64'(mem_w_valid_o), 64'd0);   // AW not accepted yet
        @(posedge clk_i);
        bypass_aw_valid_i <= 1'b0;
        dcache_aw_valid_i <= 1'b1;
        dcache_aw_id_i    <= 4'b1100;
        dcache_aw_addr_i  <= 32'(rand_bits(32));
        dcache_w_valid_i  <= 1'b1;
        dcache_w_data_i   <= d0;
        dcache_w_last_i   <= 1'b0;
        expect_w(b0, 1'b0, 1'b1);
        check("mem_aw_id_o", 64'(mem_aw_id_o), 64'(4'b1100));
        check("mem_aw_addr_o", 64'(mem_aw_addr_o), 64'(dcache_aw_addr_i));
        @(posedge clk_i);
        dcache_aw_valid_i <= 1'b0;
        bypass_w_data_i   <= b1;
        bypass_w_last_i   <= 1'b1;
        expect_w(b1, 1'b1, 1'b1);
        @(posedge clk_i);
        bypass_w_valid_i <= 1'b0;
        expect_w(d0, 1'b0, 1'b0);
        @(posedge clk_i);
        dcache_w_data_i <= d1;
        dcache_w_last_i <= 1'b1;
        expect_w(d1, 1'b1, 1'b0);
        @(posedge clk_i);
        dcache_w_valid_i <= 1'b0;
        @(negedge clk_i);
        check("mem_w_valid_o", 64'(mem_w_valid_o), 64'd0);
    endtask

    // exp is the master index (0 fetch, 1 bypass, 2 dcache)
    task automatic r_beat(input logic [3:0] id, input int exp, input logic stall);
        logic [63:0] data;
        logic        last;
        data = rand_bits(64);
        last = lfsr_bit();
        @(posedge clk_i);
        mem_r_valid_i <= 1'b1;
        mem_r_id_i    <= id;
        mem_r_data_i  <= data;
        mem_r_last_i  <= last;
        fetch_r_ready_i  <= !(stall && exp == 0);
        bypass_r_ready_i <= !(stall && exp == 1);
        dcache_r_ready_i <= !(stall && exp == 2);
        @(negedge clk_i);
        check("r_valid_o", 64'({dcache_r_valid_o, bypass_r_valid_o, fetch_r_valid_o}),
              64'(3'b001 << exp));
        check("r_data_o", exp == 0 ? fetch_r_data_o :
              exp == 1 ? bypass_r_data_o : dcache_r_data_o, data);
        check("r_id_o", 64'(exp == 0 ? fetch_r_id_o :
              exp == 1 ? bypass_r_id_o : dcache_r_id_o), 64'(id));
        check("r_last_o", 64'(exp == 0 ? fetch_r_last_o :
              exp == 1 ? bypass_r_last_o : dcache_r_last_o), 64'(last));
        check("mem_r_ready_o", 64'(mem_r_ready_o), 64'(!stall));
        @(posedge clk_i);
        mem_r_valid_i <= 1'b0;
    endtask

    task automatic b_and_full();
        @(posedge clk_i);
        mem_b_valid_i    <= 1'b1;
        mem_b_id_i       <= 4'b1001;
        bypass_b_ready_i <= 1'b1;
        dcache_b_ready_i <= 1'b1;
        @(negedge clk_i);
        check("b_valid_o", 64'({dcache_b_valid_o, bypass_b_valid_o}), 64'(2'b01));
        check("bypass_b_id_o", 64'(bypass_b_id_o), 64'(4'b1001));
        check("mem_b_ready_o", 64'(mem_b_ready_o), 64'd1);
        @(posedge clk_i);
        mem_b_id_i <= 4'b1100;
        @(negedge clk_i);
        check("b_valid_o", 64'({dcache_b_valid_o, bypass_b_valid_o}), 64'(2'b10));
        check("dcache_b_id_o", 64'(dcache_b_id_o), 64'(4'b1100));
        // five AWs without W beats against a winner FIFO of four
        for (int k = 0; k < 5; k++) begin
            @(posedge clk_i);
            mem_b_valid_i     <= 1'b0;
            bypass_aw_valid_i <= (k % 2 == 0);
            dcache_aw_valid_i <= (k % 2 == 1);
            @(negedge clk_i);
            check("mem_aw_valid_o", 64'(mem_aw_valid_o), 64'(k < 4));
            check("aw_ready_o", 64'(bypass_aw_ready_o | dcache_aw_ready_o), 64'(k < 4));
        end
        @(posedge clk_i);
        bypass_aw_valid_i <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        rst_n_i = 1'b0;
        {fetch_ar_valid_i, bypass_ar_valid_i, dcache_ar_valid_i} = '0;
        {fetch_ar_addr_i, bypass_ar_addr_i, dcache_ar_addr_i} = '0;
        {fetch_ar_id_i, bypass_ar_id_i, dcache_ar_id_i} = '0;
        {fetch_r_ready_i, bypass_r_ready_i, dcache_r_ready_i} = '0;
        {bypass_aw_valid_i, dcache_aw_valid_i, bypass_aw_addr_i, dcache_aw_addr_i} = '0;
        {bypass_aw_id_i, dcache_aw_id_i, bypass_w_valid_i, dcache_w_valid_i} = '0;
        {bypass_w_last_i, dcache_w_last_i, bypass_w_data_i, dcache_w_data_i} = '0;
        {bypass_b_ready_i, dcache_b_ready_i} = '0;
        {mem_ar_ready_i, mem_aw_ready_i, mem_w_ready_i} = '0;
        {mem_r_valid_i, mem_r_id_i, mem_r_data_i, mem_r_last_i} = '0;
        {mem_b_valid_i, mem_b_id_i} = '0;
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        reset_state();
        ar_round_robin();
        ar_backpressure();
        write_steer();
        r_beat(4'b0000, 0, 1'b0);
        r_beat(4'b1010, 1, 1'b0);
        r_beat(4'b1100, 2, 1'b0);
        r_beat(4'b1010, 1, 1'b1);   // bypass stalls the R channel
        b_and_full();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 10);
        $display("timeout: the tests did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

//--- hw/addr_arbiter.sv
// round-robin arbiter for one address channel, grant held until handshake

`timescale 1ns/1ps

module addr_arbiter #(
    parameter int PAYLOAD_W = 36
) (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  logic [mem_port_pkg::NUM_SRC-1:0]              req_valid_i,
    input  logic [mem_port_pkg::NUM_SRC-1:0][PAYLOAD_W-1:0] req_payload_i,
    output logic [mem_port_pkg::NUM_SRC-1:0]              req_ready_o,
    output logic                                          gnt_valid_o,
    output logic [PAYLOAD_W-1:0]                          gnt_payload_o,
    output mem_port_pkg::src_t                            gnt_src_o,
    input  logic                                          gnt_ready_i
);

    mem_port_pkg::src_t last_q;      // last granted index
    logic               lock_q;      // grant shown, waiting for ready
    mem_port_pkg::src_t lock_src_q;
    mem_port_pkg::src_t rr_src;
    logic               gnt_fire;

    // ------------------------------------------------------------
    // winner selection
    // ------------------------------------------------------------
    // walk down from the far end so the nearest requester wins
    always_comb begin
        int idx;
        rr_src = mem_port_pkg::SRC_FETCH;
        for (int off = mem_port_pkg::NUM_SRC; off >= 1; off--) begin
            idx = (int'(last_q) + off) % mem_port_pkg::NUM_SRC;
            if (req_valid_i[idx]) begin
                rr_src = mem_port_pkg::src_t'(idx);
            end
        end
    end

    assign gnt_src_o     = lock_q ? lock_src_q : rr_src;
    assign gnt_valid_o   = req_valid_i[gnt_src_o];
    assign gnt_payload_o = req_payload_i[gnt_src_o];
    assign gnt_fire      = gnt_valid_o & gnt_ready_i;

    // only the winner sees ready
    always_comb begin
        req_ready_o = '0;
        req_ready_o[gnt_src_o] = gnt_fire;
    end

    // ------------------------------------------------------------
    // pointer and lock
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_q     <= mem_port_pkg::SRC_DCACHE;  // index 0 wins first
            lock_q     <= 1'b0;
            lock_src_q <= mem_port_pkg::SRC_FETCH;
        end else if (gnt_fire) begin
            last_q <= gnt_src_o;
            lock_q <= 1'b0;
        end else if (gnt_valid_o) begin
            lock_q     <= 1'b1;  // back-pressure, hold this grant
            lock_src_q <= gnt_src_o;
        end
    end

endmodule

//--- hw/mem_port_pkg.sv
// shared widths, master IDs, source indices and the ID-to-master decode

package mem_port_pkg;

    // ------------------------------------------------------------
    // payload widths
    // ------------------------------------------------------------
    typedef logic [31:0] addr_t;   // memory byte address
    typedef logic [63:0] data_t;   // one data beat
    typedef logic [3:0]  id_t;     // transaction ID
    typedef logic [1:0]  src_t;    // master index

    localparam int NUM_SRC      = 3;
    localparam int AX_PAYLOAD_W = $bits(id_t) + $bits(addr_t);  // {id, addr}

    // master indices, also the lane order of every packed vector
    localparam src_t SRC_FETCH  = 2'd0;
    localparam src_t SRC_BYPASS = 2'd1;
    localparam src_t SRC_DCACHE = 2'd2;

    // ------------------------------------------------------------
    // ID ranges
    // ------------------------------------------------------------
    localparam id_t ID_FETCH       = 4'b0000;
    localparam id_t ID_DCACHE      = 4'b1100;
    localparam id_t ID_BYPASS_BASE = 4'b1000;  // bypass owns 1000..1011

    // accepted writes still waiting for their W beats
    localparam int WFIFO_DEPTH = 4;
    localparam int WFIFO_PTR_W = $clog2(WFIFO_DEPTH);

    // unknown IDs fall to the dcache lane
    function automatic src_t id_to_src(input id_t id);
        if (id == ID_DCACHE) begin
            return SRC_DCACHE;
        end else if (id[3:2] == ID_BYPASS_BASE[3:2]) begin
            return SRC_BYPASS;
        end else if (id == ID_FETCH) begin
            return SRC_FETCH;
        end
        return SRC_DCACHE;
    endfunction

endpackage

//--- hw/mem_port_top.sv
// memory port merger: AR/AW arbiters, W steering and R/B routing

`timescale 1ns/1ps

module mem_port_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // instruction fetch, read only
    input  logic                 fetch_ar_valid_i,
    input  mem_port_pkg::addr_t  fetch_ar_addr_i,
    input  mem_port_pkg::id_t    fetch_ar_id_i,
    output logic                 fetch_ar_ready_o,
    output logic                 fetch_r_valid_o,
    output mem_port_pkg::data_t  fetch_r_data_o,
    output mem_port_pkg::id_t    fetch_r_id_o,
    output logic                 fetch_r_last_o,
    input  logic                 fetch_r_ready_i,
    // uncached bypass
    input  logic                 bypass_ar_valid_i,
    input  mem_port_pkg::addr_t  bypass_ar_addr_i,
    input  mem_port_pkg::id_t    bypass_ar_id_i,
    output logic                 bypass_ar_ready_o,
    output logic                 bypass_r_valid_o,
    output mem_port_pkg::data_t  bypass_r_data_o,
    output mem_port_pkg::id_t    bypass_r_id_o,
    output logic                 bypass_r_last_o,
    input  logic                 bypass_r_ready_i,
    input  logic                 bypass_aw_valid_i,
    input  mem_port_pkg::addr_t  bypass_aw_addr_i,
    input  mem_port_pkg::id_t    bypass_aw_id_i,
    output logic                 bypass_aw_ready_o,
    input  logic                 bypass_w_valid_i,
    input  mem_port_pkg::data_t  bypass_w_data_i,
    input  logic                 bypass_w_last_i,
    output logic                 bypass_w_ready_o,
    output logic                 bypass_b_valid_o,
    output mem_port_pkg::id_t    bypass_b_id_o,
    input  logic                 bypass_b_ready_i,
    // dcache refill and writeback
    input  logic                 dcache_ar_valid_i,
    input  mem_port_pkg::addr_t  dcache_ar_addr_i,
    input  mem_port_pkg::id_t    dcache_ar_id_i,
    output logic                 dcache_ar_ready_o,
    output logic                 dcache_r_valid_o,
    output mem_port_pkg::data_t  dcache_r_data_o,
    output mem_port_pkg::id_t    dcache_r_id_o,
    output logic                 dcache_r_last_o,
    input  logic                 dcache_r_ready_i,
    input  logic                 dcache_aw_valid_i,
    input  mem_port_pkg::addr_t  dcache_aw_addr_i,
    input  mem_port_pkg::id_t    dcache_aw_id_i,
    output logic                 dcache_aw_ready_o,
    input  logic                 dcache_w_valid_i,
    input  mem_port_pkg::data_t  dcache_w_data_i,
    input  logic                 dcache_w_last_i,
    output logic                 dcache_w_ready_o,
    output logic                 dcache_b_valid_o,
    output mem_port_pkg::id_t    dcache_b_id_o,
    input  logic                 dcache_b_ready_i,
    // memory side
    output logic                 mem_ar_valid_o,
    output mem_port_pkg::addr_t  mem_ar_addr_o,
    output mem_port_pkg::id_t    mem_ar_id_o,
    input  logic                 mem_ar_ready_i,
    output logic                 mem_aw_valid_o,
    output mem_port_pkg::addr_t  mem_aw_addr_o,
    output mem_port_pkg::id_t    mem_aw_id_o,
    input  logic                 mem_aw_ready_i,
    output logic                 mem_w_valid_o,
    output mem_port_pkg::data_t  mem_w_data_o,
    output logic                 mem_w_last_o,
    input  logic                 mem_w_ready_i,
    input  logic                 mem_r_valid_i,
    input  mem_port_pkg::data_t  mem_r_data_i,
    input  mem_port_pkg::id_t    mem_r_id_i,
    input  logic                 mem_r_last_i,
    output logic                 mem_r_ready_o,
    input  logic                 mem_b_valid_i,
    input  mem_port_pkg::id_t    mem_b_id_i,
    output logic                 mem_b_ready_o
);

    localparam int N  = mem_port_pkg::NUM_SRC;
    localparam int PW = mem_port_pkg::AX_PAYLOAD_W;

    // lanes indexed by src_t: {dcache, bypass, fetch}
    logic [N-1:0]                        ar_valid, ar_ready, aw_valid, aw_ready;
    logic [N-1:0][PW-1:0]                ar_payload, aw_payload;
    logic [N-1:0]                        w_valid, w_last, w_ready;
    mem_port_pkg::data_t [N-1:0]         w_data, r_data;
    logic [N-1:0]                        r_valid, r_last, r_ready, b_valid, b_ready;
    mem_port_pkg::id_t [N-1:0]           r_id, b_id;
    logic [PW-1:0]                       ar_gnt_payload, aw_gnt_payload;
    logic                                aw_gnt_valid, aw_gnt_ready, aw_fire, wr_full;
    mem_port_pkg::src_t                  aw_gnt_src;

    // ------------------------------------------------------------
    // lane packing, fetch write lanes idle
    // ------------------------------------------------------------
    assign ar_valid   = {dcache_ar_valid_i, bypass_ar_valid_i, fetch_ar_valid_i};
    assign ar_payload = {{dcache_ar_id_i, dcache_ar_addr_i},
                         {bypass_ar_id_i, bypass_ar_addr_i},
                         {fetch_ar_id_i,  fetch_ar_addr_i}};
    assign aw_valid   = {dcache_aw_valid_i, bypass_aw_valid_i, 1'b0};
    assign aw_payload = {{dcache_aw_id_i, dcache_aw_addr_i},
                         {bypass_aw_id_i, bypass_aw_addr_i}, PW'(0)};
    assign w_valid    = {dcache_w_valid_i, bypass_w_valid_i, 1'b0};
    assign w_last     = {dcache_w_last_i,  bypass_w_last_i,  1'b0};
    assign w_data     = {dcache_w_data_i,  bypass_w_data_i,  64'd0};
    assign r_ready    = {dcache_r_ready_i, bypass_r_ready_i, fetch_r_ready_i};
    assign b_ready    = {dcache_b_ready_i, bypass_b_ready_i, 1'b0};  // no fetch B port

    assign {dcache_ar_ready_o, bypass_ar_ready_o, fetch_ar_ready_o} = ar_ready;
    assign dcache_aw_ready_o = aw_ready[mem_port_pkg::SRC_DCACHE];
    assign bypass_aw_ready_o = aw_ready[mem_port_pkg::SRC_BYPASS];
    assign dcache_w_ready_o  = w_ready[mem_port_pkg::SRC_DCACHE];
    assign bypass_w_ready_o  = w_ready[mem_port_pkg::SRC_BYPASS];

    // ------------------------------------------------------------
    // address arbitration
    // ------------------------------------------------------------
    addr_arbiter #(.PAYLOAD_W(PW)) ar_arbiter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (ar_valid),
        .req_payload_i (ar_payload),
        .req_ready_o   (ar_ready),
        .gnt_valid_o   (mem_ar_valid_o),
        .gnt_payload_o (ar_gnt_payload),
        .gnt_src_o     (),
        .gnt_ready_i   (mem_ar_ready_i)
    );
    assign {mem_ar_id_o, mem_ar_addr_o} = ar_gnt_payload;

    addr_arbiter #(.PAYLOAD_W(PW)) aw_arbiter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (aw_valid),
        .req_payload_i (aw_payload),
        .req_ready_o   (aw_ready),
        .gnt_valid_o   (aw_gnt_valid),
        .gnt_payload_o (aw_gnt_payload),
        .gnt_src_o     (aw_gnt_src),
        .gnt_ready_i   (aw_gnt_ready)
    );

    // no new AW while the winner FIFO has no room
    assign mem_aw_valid_o = aw_gnt_valid & ~wr_full;
    assign aw_gnt_ready   = mem_aw_ready_i & ~wr_full;
    assign aw_fire        = aw_gnt_valid & aw_gnt_ready;
    assign {mem_aw_id_o, mem_aw_addr_o} = aw_gnt_payload;

    // ------------------------------------------------------------
    // write data and responses
    // ------------------------------------------------------------
    write_router write_router_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .aw_fire_i     (aw_fire),
        .aw_src_i      (aw_gnt_src),
        .full_o        (wr_full),
        .w_valid_i     (w_valid),
        .w_last_i      (w_last),
        .w_data_i      (w_data),
        .w_ready_o     (w_ready),
        .mem_w_valid_o (mem_w_valid_o),
        .mem_w_data_o  (mem_w_data_o),
        .mem_w_last_o  (mem_w_last_o),
        .mem_w_ready_i (mem_w_ready_i)
    );

    resp_router resp_router_inst (
        .mem_r_valid_i (mem_r_valid_i),
        .mem_r_id_i    (mem_r_id_i),
        .mem_r_data_i  (mem_r_data_i),
        .mem_r_last_i  (mem_r_last_i),
        .mem_r_ready_o (mem_r_ready_o),
        .r_valid_o     (r_valid),
        .r_data_o      (r_data),
        .r_id_o        (r_id),
        .r_last_o      (r_last),
        .r_ready_i     (r_ready),
        .mem_b_valid_i (mem_b_valid_i),
        .mem_b_id_i    (mem_b_id_i),
        .mem_b_ready_o (mem_b_ready_o),
        .b_valid_o     (b_valid),
        .b_id_o        (b_id),
        .b_ready_i     (b_ready)
    );

    // fan-out to the masters
    assign {dcache_r_valid_o, bypass_r_valid_o, fetch_r_valid_o} = r_valid;
    assign {dcache_r_data_o,  bypass_r_data_o,  fetch_r_data_o}  = r_data;
    assign {dcache_r_id_o,    bypass_r_id_o,    fetch_r_id_o}    = r_id;
    assign {dcache_r_last_o,  bypass_r_last_o,  fetch_r_last_o}  = r_last;
    assign dcache_b_valid_o = b_valid[mem_port_pkg::SRC_DCACHE];
    assign bypass_b_valid_o = b_valid[mem_port_pkg::SRC_BYPASS];
    assign dcache_b_id_o    = b_id[mem_port_pkg::SRC_DCACHE];
    assign bypass_b_id_o    = b_id[mem_port_pkg::SRC_BYPASS];

endmodule

//--- hw/resp_router.sv
// R and B channel demultiplexing to the masters by transaction ID

`timescale 1ns/1ps

module resp_router (
    input  logic                                         mem_r_valid_i,
    input  mem_port_pkg::id_t                            mem_r_id_i,
    input  mem_port_pkg::data_t                          mem_r_data_i,
    input  logic                                         mem_r_last_i,
    output logic                                         mem_r_ready_o,
    output logic [mem_port_pkg::NUM_SRC-1:0]             r_valid_o,
    output mem_port_pkg::data_t [mem_port_pkg::NUM_SRC-1:0] r_data_o,
    output mem_port_pkg::id_t [mem_port_pkg::NUM_SRC-1:0]   r_id_o,
    output logic [mem_port_pkg::NUM_SRC-1:0]             r_last_o,
    input  logic [mem_port_pkg::NUM_SRC-1:0]             r_ready_i,
    input  logic                                         mem_b_valid_i,
    input  mem_port_pkg::id_t                            mem_b_id_i,
    output logic                                         mem_b_ready_o,
    output logic [mem_port_pkg::NUM_SRC-1:0]             b_valid_o,
    output mem_port_pkg::id_t [mem_port_pkg::NUM_SRC-1:0]   b_id_o,
    input  logic [mem_port_pkg::NUM_SRC-1:0]             b_ready_i
);

    mem_port_pkg::src_t r_sel;
    mem_port_pkg::src_t b_sel;

    assign r_sel = mem_port_pkg::id_to_src(mem_r_id_i);
    assign b_sel = mem_port_pkg::id_to_src(mem_b_id_i);

    // ------------------------------------------------------------
    // R channel
    // ------------------------------------------------------------
    always_comb begin
        r_valid_o = '0;
        r_valid_o[r_sel] = mem_r_valid_i;
        for (int i = 0; i < mem_port_pkg::NUM_SRC; i++) begin
            r_data_o[i] = mem_r_data_i;   // fields go everywhere
            r_id_o[i]   = mem_r_id_i;
            r_last_o[i] = mem_r_last_i;
        end
    end

    assign mem_r_ready_o = r_ready_i[r_sel];

    // ------------------------------------------------------------
    // B channel
    // ------------------------------------------------------------
    always_comb begin
        b_valid_o = '0;
        b_valid_o[b_sel] = mem_b_valid_i;
        for (int i = 0; i < mem_port_pkg::NUM_SRC; i++) begin
            b_id_o[i] = mem_b_id_i;
        end
    end

    assign mem_b_ready_o = b_ready_i[b_sel];  // stalls on the selected master

endmodule

//--- hw/write_router.sv
// FIFO of AW winners and the W beat multiplexer it steers

`timescale 1ns/1ps

module write_router (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         aw_fire_i,
    input  mem_port_pkg::src_t                           aw_src_i,
    output logic                                         full_o,
    input  logic [mem_port_pkg::NUM_SRC-1:0]             w_valid_i,
    input  logic [mem_port_pkg::NUM_SRC-1:0]             w_last_i,
    input  mem_port_pkg::data_t [mem_port_pkg::NUM_SRC-1:0] w_data_i,
    output logic [mem_port_pkg::NUM_SRC-1:0]             w_ready_o,
    output logic                                         mem_w_valid_o,
    output mem_port_pkg::data_t                          mem_w_data_o,
    output logic                                         mem_w_last_o,
    input  logic                                         mem_w_ready_i
);

    // ------------------------------------------------------------
    // winner FIFO
    // ------------------------------------------------------------
    mem_port_pkg::src_t                    fifo_q [mem_port_pkg::WFIFO_DEPTH];
    logic [mem_port_pkg::WFIFO_PTR_W-1:0]  rd_ptr_q;
    logic [mem_port_pkg::WFIFO_PTR_W:0]    cnt_q;
    logic [mem_port_pkg::WFIFO_PTR_W-1:0]  wr_ptr;
    logic                                  empty;
    logic                                  pop;
    mem_port_pkg::src_t                    w_sel;

    assign empty  = (cnt_q == '0);
    assign full_o = (cnt_q == mem_port_pkg::WFIFO_DEPTH[mem_port_pkg::WFIFO_PTR_W:0]);
    assign wr_ptr = rd_ptr_q + cnt_q[mem_port_pkg::WFIFO_PTR_W-1:0];  // wraps

    // fetch never writes, so its lane is the idle steer
    assign w_sel = empty ? mem_port_pkg::SRC_FETCH : fifo_q[rd_ptr_q];

    // ------------------------------------------------------------
    // W multiplexer
    // ------------------------------------------------------------
    assign mem_w_valid_o = w_valid_i[w_sel] & ~empty;
    assign mem_w_data_o  = w_data_i[w_sel];
    assign mem_w_last_o  = w_last_i[w_sel];
    assign pop           = mem_w_valid_o & mem_w_ready_i & mem_w_last_o;

    always_comb begin
        w_ready_o = '0;
        w_ready_o[w_sel] = mem_w_ready_i & ~empty;
    end

    // payload storage
    always_ff @(posedge clk_i) begin
        if (aw_fire_i) begin
            fifo_q[wr_ptr] <= aw_src_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({aw_fire_i, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;  // none, or push and pop together
            endcase
        end
    end

endmodule

//--- tb.f
hw/mem_port_pkg.sv
hw/addr_arbiter.sv
hw/write_router.sv
hw/resp_router.sv
hw/mem_port_top.sv
bench/tb_mem_port.sv
